/* src/dcache_pkg.sv */
package dcache_pkg;

    // cache geometry
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int WORDS      = 4;    // words per line
    localparam int OFFSET_W   = 4;    // byte offset inside a line
    localparam int WORD_OFF_W = 2;
    localparam int SETS       = 16;
    localparam int INDEX_W    = 4;
    localparam int WAYS       = 2;
    localparam int WAY_W      = 1;

    // address fields, tag | index | offset
    localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;
    localparam int LINE_W     = WORDS * DATA_W;

    // cpu size field, same encoding as the core uses
    typedef enum logic [1:0] {
        sz_byte = 2'd0,
        sz_half = 2'd1,
        sz_word = 2'd2
    } access_size_e;

    typedef enum logic [1:0] {
        st_idle      = 2'd0,
        st_writeback = 2'd1,  // dirty victim goes out word by word
        st_refill    = 2'd2,
        st_install   = 2'd3
    } cache_state_e;

endpackage

/* src/dcache_tag_ram.sv */
`timescale 1ns/1ps

module dcache_tag_ram (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [dcache_pkg::INDEX_W-1:0] index,
    input  logic                           wen,
    input  logic                           set_valid,
    input  logic                           set_dirty,
    input  logic [dcache_pkg::TAG_W-1:0]   tag_in,
    output logic                           valid,
    output logic                           dirty,
    output logic [dcache_pkg::TAG_W-1:0]   tag_out
);
    import dcache_pkg::*;

    logic [SETS-1:0]  valid_q;
    logic             dirty_mem [SETS];
    logic [TAG_W-1:0] tag_mem   [SETS];

    // valid bits must come up cleared
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (wen) begin
            valid_q[index] <= set_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (wen) begin
            dirty_mem[index] <= set_dirty;
            tag_mem[index]   <= tag_in;
        end
    end

    // lookup is combinational so a hit answers in the request cycle
    assign valid   = valid_q[index];
    assign dirty   = dirty_mem[index];
    assign tag_out = tag_mem[index];

endmodule

/* src/dcache_data_ram.sv */
`timescale 1ns/1ps

module dcache_data_ram (
    input  logic                              clk,
    input  logic [dcache_pkg::INDEX_W-1:0]    index,
    input  logic                              line_wen,
    input  logic [dcache_pkg::LINE_W-1:0]     line_in,
    input  logic                              word_wen,
    input  logic [dcache_pkg::WORD_OFF_W-1:0] word_sel,
    input  logic [3:0]                        byte_en,
    input  logic [dcache_pkg::DATA_W-1:0]     word_in,
    output logic [dcache_pkg::LINE_W-1:0]     line_out
);
    import dcache_pkg::*;

    logic [LINE_W-1:0] line_mem [SETS];
    logic [LINE_W-1:0] merged;

    // store hit, patch only the enabled byte lanes of one word
    always_comb begin
        merged = line_mem[index];
        for (int b = 0; b < 4; b++) begin
            if (byte_en[b]) begin
                merged[word_sel*DATA_W + b*8 +: 8] = word_in[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (line_wen) begin
            line_mem[index] <= line_in;     // install of a refilled line
        end else if (word_wen) begin
            line_mem[index] <= merged;
        end
    end

    // whole line out, the top picks the word it needs
    assign line_out = line_mem[index];

endmodule

/* src/dcache_replacement.sv */
`timescale 1ns/1ps

module dcache_replacement (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [dcache_pkg::INDEX_W-1:0] index,
    input  logic                           install,
    output logic [dcache_pkg::WAY_W-1:0]   victim
);
    import dcache_pkg::*;

    logic [WAY_W-1:0] ptr [SETS];   // one round-robin pointer per set

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < SETS; s++) begin
                ptr[s] <= '0;
            end
        end else if (install) begin
            // advance only after the victim way has been written
            if (ptr[index] == WAY_W'(WAYS - 1)) begin
                ptr[index] <= '0;
            end else begin
                ptr[index] <= ptr[index] + 1'b1;
            end
        end
    end

    assign victim = ptr[index];

endmodule

/* src/dcache_controller.sv */
`timescale 1ns/1ps

module dcache_controller (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              cpu_req,
    input  logic                              wr,
    input  dcache_pkg::access_size_e          size,
    input  logic [1:0]                        byte_sel,
    input  logic                              hit,
    input  logic                              victim_dirty,
    input  logic                              mem_addr_ok,
    input  logic                              mem_data_ok,
    input  logic [dcache_pkg::DATA_W-1:0]     mem_rdata,
    output dcache_pkg::cache_state_e          state,
    output logic [dcache_pkg::WORD_OFF_W-1:0] beat,
    output logic                              tag_wen,
    output logic                              line_wen,
    output logic                              word_wen,
    output logic [3:0]                        byte_en,
    output logic                              set_dirty,
    output logic                              install,
    output logic [dcache_pkg::LINE_W-1:0]     refill_line,
    output logic                              mem_req,
    output logic                              mem_wen,
    output logic                              awvalid,
    output logic                              wlast
);
    import dcache_pkg::*;

    cache_state_e state_next;
    logic         addr_taken;   // address phase of this beat already accepted
    logic         mem_phase;
    logic         beat_done;
    logic         last_beat;
    logic         store_hit;

    assign mem_phase = (state == st_writeback) || (state == st_refill);
    assign last_beat = beat == WORD_OFF_W'(WORDS - 1);

    // one beat in flight: request until address accepted, then wait for data
    assign mem_req   = mem_phase && !addr_taken;
    assign mem_wen   = state == st_writeback;
    assign beat_done = mem_phase && mem_data_ok && (addr_taken || mem_addr_ok);

    // burst markers for the write-back
    assign awvalid = mem_req && mem_wen && (beat == '0);
    assign wlast   = mem_req && mem_wen && last_beat;

    assign store_hit = (state == st_idle) && cpu_req && wr && hit;
    assign install   = state == st_install;

    // store hit marks the line dirty, install brings it in clean
    assign word_wen  = store_hit;
    assign line_wen  = install;
    assign tag_wen   = store_hit || install;
    assign set_dirty = store_hit;

    // lane enables from size and the low address bits
    always_comb begin
        case (size)
            sz_byte: byte_en = 4'b0001 << byte_sel;
            sz_half: byte_en = byte_sel[1] ? 4'b1100 : 4'b0011;
            default: byte_en = 4'b1111;
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (cpu_req && !hit) begin
                    state_next = victim_dirty ? st_writeback : st_refill;
                end
            end
            st_writeback: begin
                if (beat_done && last_beat) begin
                    state_next = st_refill;
                end
            end
            st_refill: begin
                if (beat_done && last_beat) begin
                    state_next = st_install;
                end
            end
            default: state_next = st_idle;   // install lasts one cycle
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= st_idle;
            beat       <= '0;
            addr_taken <= 1'b0;
        end else begin
            state <= state_next;
            if (beat_done) begin
                addr_taken <= 1'b0;
                beat       <= beat + 1'b1;   // wraps to 0 after the last word
            end else if (mem_req && mem_addr_ok) begin
                addr_taken <= 1'b1;
            end
        end
    end

    // collect refill words in beat order
    always_ff @(posedge clk) begin
        if (beat_done && (state == st_refill)) begin
            refill_line[beat*DATA_W +: DATA_W] <= mem_rdata;
        end
    end

endmodule

/* src/dcache.sv */
`timescale 1ns/1ps

module dcache (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cpu_req,
    input  logic                          wr,
    input  dcache_pkg::access_size_e      size,
    input  logic [dcache_pkg::ADDR_W-1:0] data_addr,
    input  logic [dcache_pkg::DATA_W-1:0] wdata,
    output logic                          cpu_addr_ok,
    output logic                          cpu_data_ok,
    output logic [dcache_pkg::DATA_W-1:0] data_rdata,
    output logic                          mem_req,
    output logic                          mem_wen,
    output logic [dcache_pkg::ADDR_W-1:0] mem_addr,
    output logic [dcache_pkg::DATA_W-1:0] mem_wdata,
    input  logic [dcache_pkg::DATA_W-1:0] mem_rdata,
    input  logic                          mem_addr_ok,
    input  logic                          mem_data_ok,
    output logic                          wlast,
    output logic                          awvalid
);
    import dcache_pkg::*;

    logic [TAG_W-1:0]      req_tag;
    logic [INDEX_W-1:0]    index;
    logic [WORD_OFF_W-1:0] word_off;
    logic [1:0]            byte_sel;

    logic [WAYS-1:0]       way_valid;
    logic [WAYS-1:0]       way_dirty;
    logic [WAYS-1:0]       way_match;
    logic [TAG_W-1:0]      way_tag  [WAYS];
    logic [LINE_W-1:0]     way_line [WAYS];

    logic                  hit;
    logic [WAY_W-1:0]      hit_way;
    logic [WAY_W-1:0]      victim;
    logic [WAY_W-1:0]      wr_way;
    logic                  victim_dirty;

    cache_state_e          state;
    logic [WORD_OFF_W-1:0] beat;
    logic                  tag_wen;
    logic                  line_wen;
    logic                  word_wen;
    logic [3:0]            byte_en;
    logic                  set_dirty;
    logic                  install;
    logic [LINE_W-1:0]     refill_line;

    assign req_tag  = data_addr[ADDR_W-1 -: TAG_W];
    assign index    = data_addr[OFFSET_W +: INDEX_W];
    assign word_off = data_addr[2 +: WORD_OFF_W];
    assign byte_sel = data_addr[1:0];

    // store hits land in the hit way, installs in the victim
    assign wr_way = (state == st_idle) ? hit_way : victim;

    generate
        for (genvar w = 0; w < WAYS; w++) begin : g_way
            dcache_tag_ram tag_ram_i (
                .clk      (clk),
                .rst_n    (rst_n),
                .index    (index),
                .wen      (tag_wen && (wr_way == WAY_W'(w))),
                .set_valid(1'b1),   // every write leaves the entry valid
                .set_dirty(set_dirty),
                .tag_in   (req_tag),
                .valid    (way_valid[w]),
                .dirty    (way_dirty[w]),
                .tag_out  (way_tag[w])
            );

            dcache_data_ram data_ram_i (
                .clk     (clk),
                .index   (index),
                .line_wen(line_wen && (wr_way == WAY_W'(w))),
                .line_in (refill_line),
                .word_wen(word_wen && (wr_way == WAY_W'(w))),
                .word_sel(word_off),
                .byte_en (byte_en),
                .word_in (wdata),
                .line_out(way_line[w])
            );

            assign way_match[w] = way_valid[w] && (way_tag[w] == req_tag);
        end
    endgenerate

    assign hit = |way_match;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (way_match[w]) begin
                hit_way = WAY_W'(w);
            end
        end
    end

    assign victim_dirty = way_valid[victim] && way_dirty[victim];

    // hit answers in the same cycle, misses wait for the install
    assign cpu_addr_ok = cpu_req && (state == st_idle) && hit;
    assign cpu_data_ok = cpu_req && (state == st_idle) && hit;
    assign data_rdata  = way_line[hit_way][word_off*DATA_W +: DATA_W];

    // write-back uses the victim tag, refill the request tag
    assign mem_addr  = mem_wen ? {way_tag[victim], index, beat, 2'b00}
                               : {req_tag, index, beat, 2'b00};
    assign mem_wdata = way_line[victim][beat*DATA_W +: DATA_W];

    dcache_replacement replacement_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .index  (index),
        .install(install),
        .victim (victim)
    );

    dcache_controller controller_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .cpu_req     (cpu_req),
        .wr          (wr),
        .size        (size),
        .byte_sel    (byte_sel),
        .hit         (hit),
        .victim_dirty(victim_dirty),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .mem_rdata   (mem_rdata),
        .state       (state),
        .beat        (beat),
        .tag_wen     (tag_wen),
        .line_wen    (line_wen),
        .word_wen    (word_wen),
        .byte_en     (byte_en),
        .set_dirty   (set_dirty),
        .install     (install),
        .refill_line (refill_line),
        .mem_req     (mem_req),
        .mem_wen     (mem_wen),
        .awvalid     (awvalid),
        .wlast       (wlast)
    );

endmodule

/* test/dcache_mem_model.sv */
`timescale 1ns/1ps

module dcache_mem_model #(
    parameter int DEPTH     = 1024,
    parameter int MAX_STALL = 3,
    parameter int SEED      = 1
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        mem_req,
    input  logic        mem_wen,
    input  logic [31:0] mem_addr,
    input  logic [31:0] mem_wdata,
    output logic        mem_addr_ok,
    output logic        mem_data_ok,
    output logic [31:0] mem_rdata
);
    localparam int AW = $clog2(DEPTH);

    typedef enum logic [1:0] {ph_addr, ph_data, ph_done} phase_e;

    logic [31:0] mem [DEPTH];
    phase_e      phase;
    int          seed;
    int          stall;
    int          split;
    int          addr_wait;
    int          data_wait;

    initial begin
        seed = SEED;
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = (i * 32'h9e37_79b1) ^ 32'h0bad_f00d;   // every word differs
        end
    end

    // the cache holds address and write data until the beat is done
    task automatic finish_beat();
        mem_data_ok <= 1'b1;
        if (mem_wen) begin
            mem[mem_addr[AW+1:2]] = mem_wdata;
        end else begin
            mem_rdata <= mem[mem_addr[AW+1:2]];
        end
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase       <= ph_addr;
            mem_addr_ok <= 1'b0;
            mem_data_ok <= 1'b0;
            mem_rdata   <= '0;
            addr_wait   <= 0;
            data_wait   <= 0;
        end else begin
            mem_addr_ok <= 1'b0;
            mem_data_ok <= 1'b0;
            case (phase)
                ph_addr: begin
                    if (mem_req && addr_wait > 0) begin
                        addr_wait <= addr_wait - 1;
                    end else if (mem_req) begin
                        mem_addr_ok <= 1'b1;
                        if (data_wait == 0) begin
                            finish_beat();   // data together with the address
                            phase <= ph_done;
                        end else begin
                            phase <= ph_data;
                        end
                    end
                end
                ph_data: begin
                    if (data_wait > 1) begin
                        data_wait <= data_wait - 1;
                    end else begin
                        finish_beat();
                        phase <= ph_done;
                    end
                end
                default: begin
                    // one stall per beat, split between address and data
                    stall = $unsigned($random(seed)) % (MAX_STALL + 1);
                    split = $unsigned($random(seed)) % (stall + 1);
                    addr_wait <= split;
                    data_wait <= stall - split;
                    phase     <= ph_addr;
                end
            endcase
        end
    end

endmodule

/* test/dcache_checker.sv */
`timescale 1ns/1ps

module dcache_checker (
    input logic                          clk,
    input logic                          rst_n,
    input logic                          cpu_req,
    input logic                          cpu_data_ok,
    input logic                          mem_req,
    input logic                          mem_wen,
    input logic                          mem_addr_ok,
    input logic [dcache_pkg::ADDR_W-1:0] mem_addr,
    input logic                          awvalid,
    input logic                          wlast
);

    int fail_count = 0;   // failed assertions so far

    // a beat keeps its request and address until memory takes the address
    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && !mem_addr_ok |=> mem_req && $stable(mem_addr))
        else begin
            fail_count++;
            $error("mem_req or mem_addr changed before mem_addr_ok");
        end

    data_ok_with_req: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_data_ok |-> cpu_req)
        else begin
            fail_count++;
            $error("cpu_data_ok without cpu_req");
        end

    wlast_is_write: assert property (@(posedge clk) disable iff (!rst_n)
        wlast |-> mem_wen)
        else begin
            fail_count++;
            $error("wlast on a read beat");
        end

    no_markers_on_refill: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && !mem_wen |-> !awvalid && !wlast)
        else begin
            fail_count++;
            $error("awvalid or wlast during a refill");
        end

endmodule

bind dcache dcache_checker checker_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .cpu_req    (cpu_req),
    .cpu_data_ok(cpu_data_ok),
    .mem_req    (mem_req),
    .mem_wen    (mem_wen),
    .mem_addr_ok(mem_addr_ok),
    .mem_addr   (mem_addr),
    .awvalid    (awvalid),
    .wlast      (wlast)
);

/* test/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb;
    import dcache_pkg::*;

    localparam int MEM_DEPTH      = 1024;
    localparam int MEM_AW         = 10;
    localparam int MAX_STALL      = 3;
    localparam int NUM_OPS        = 300;
    localparam int DIRECTED_OPS   = 16;
    localparam int SEED           = 32'ha4b9c412;
    localparam int TIMEOUT_CYCLES = (NUM_OPS + DIRECTED_OPS) * (2 * WORDS * (MAX_STALL + 2) + 4);

    logic         clk = 1'b0;
    logic         rst_n;
    logic         cpu_req;
    logic         wr;
    access_size_e size;
    logic [31:0]  data_addr;
    logic [31:0]  wdata;
    logic         cpu_addr_ok;
    logic         cpu_data_ok;
    logic [31:0]  data_rdata;
    logic         mem_req;
    logic         mem_wen;
    logic [31:0]  mem_addr;
    logic [31:0]  mem_wdata;
    logic [31:0]  mem_rdata;
    logic         mem_addr_ok;
    logic         mem_data_ok;
    logic         wlast;
    logic         awvalid;

    logic [31:0]  ref_mem [MEM_DEPTH];
    int           seed;
    int           load_errors = 0;
    int           bus_errors  = 0;
    int           seq_errors  = 0;
    int           cycles      = 0;
    int           wb_count    = 0;
    int           rf_count    = 0;
    logic [1:0]   wb_beat     = 2'd0;
    logic [1:0]   rf_beat     = 2'd0;

    always #50 clk = ~clk;

    dcache dcache_i (
        .clk(clk), .rst_n(rst_n), .cpu_req(cpu_req), .wr(wr), .size(size),
        .data_addr(data_addr), .wdata(wdata), .cpu_addr_ok(cpu_addr_ok),
        .cpu_data_ok(cpu_data_ok), .data_rdata(data_rdata), .mem_req(mem_req),
        .mem_wen(mem_wen), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata), .mem_addr_ok(mem_addr_ok), .mem_data_ok(mem_data_ok),
        .wlast(wlast), .awvalid(awvalid)
    );

    dcache_mem_model #(.DEPTH(MEM_DEPTH), .MAX_STALL(MAX_STALL), .SEED(SEED)) mem_model_i (
        .clk(clk), .rst_n(rst_n), .mem_req(mem_req), .mem_wen(mem_wen),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_addr_ok(mem_addr_ok),
        .mem_data_ok(mem_data_ok), .mem_rdata(mem_rdata)
    );

    // returns the word as it was before the access, then merges a store by lanes
    function automatic logic [31:0] ref_access(input logic w, input access_size_e sz,
                                               input logic [31:0] addr, input logic [31:0] wd);
        logic [31:0] old_word;
        int          nbytes;
        int          first;
        old_word = ref_mem[addr[MEM_AW+1:2]];
        nbytes   = (sz == sz_byte) ? 1 : (sz == sz_half) ? 2 : 4;
        first    = addr[1:0];
        // a store of n bytes covers n lanes upward from its byte offset
        for (int b = 0; b < 4; b++) begin
            if (w && b >= first && b < first + nbytes) begin
                ref_mem[addr[MEM_AW+1:2]][b*8 +: 8] = wd[b*8 +: 8];
            end
        end
        return old_word;
    endfunction

    always @(posedge clk) begin
        logic [31:0] expected;
        if (rst_n && cpu_addr_ok !== cpu_data_ok) begin
            seq_errors++;
            $display("[ERROR] %0t: cpu_addr_ok %b and cpu_data_ok %b disagree",
                     $time, cpu_addr_ok, cpu_data_ok);
        end
        if (rst_n && cpu_data_ok) begin
            expected = ref_access(wr, size, data_addr, wdata);
            if (!wr && data_rdata !== expected) begin
                load_errors++;
                $display("[ERROR] %0t: load 0x%08h returned 0x%08h, expected 0x%08h",
                         $time, data_addr, data_rdata, expected);
            end
        end
    end

    // word order, burst markers and write-back data on the memory port
    always @(posedge clk) begin
        if (rst_n && mem_req && mem_addr_ok && mem_wen) begin
            if (mem_addr[3:2] != wb_beat || awvalid != (wb_beat == 2'd0)
                    || wlast != (wb_beat == 2'd3)
                    || mem_wdata !== ref_mem[mem_addr[MEM_AW+1:2]]) begin
                bus_errors++;
                $display("[ERROR] %0t: write-back beat %0d to 0x%08h data 0x%08h",
                         $time, wb_beat, mem_addr, mem_wdata);
                $display("        awvalid %b wlast %b", awvalid, wlast);
            end
            wb_beat  <= wb_beat + 2'd1;
            wb_count <= wb_count + 1;
        end else if (rst_n && mem_req && mem_addr_ok) begin
            if (mem_addr[3:2] != rf_beat) begin
                bus_errors++;
                $display("[ERROR] %0t: refill beat %0d at 0x%08h", $time, rf_beat, mem_addr);
            end
            rf_beat  <= rf_beat + 2'd1;
            rf_count <= rf_count + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    // called at a rising edge; returns at the edge that ends the cpu_data_ok cycle
    task automatic access(input logic w, input access_size_e sz, input logic [31:0] addr,
                          input logic [31:0] wd, output int lat);
        cpu_req   <= 1'b1;
        wr        <= w;
        size      <= sz;
        data_addr <= addr;
        wdata     <= wd;
        lat = 0;
        @(posedge clk);
        while (!cpu_data_ok) begin
            lat++;
            @(posedge clk);
        end
    endtask

    task automatic expect_hit(input int lat, input logic [31:0] addr);
        if (lat != 0) begin
            seq_errors++;
            $display("[ERROR] %0t: hit at 0x%08h took %0d cycles", $time, addr, lat);
        end
    endtask

    initial begin
        int           lat;
        int           rf0;
        int           wb0;
        int           r;
        int           assert_errors;
        logic [31:0]  addr;
        access_size_e sz;
        rst_n     <= 1'b0;
        cpu_req   <= 1'b0;
        wr        <= 1'b0;
        size      <= sz_word;
        data_addr <= '0;
        wdata     <= '0;
        seed = SEED;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            ref_mem[i] = (i * 32'h9e37_79b1) ^ 32'h0bad_f00d;   // same contents as the memory
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        if (mem_req || awvalid || wlast || cpu_data_ok) begin
            seq_errors++;
            $display("[ERROR] %0t: memory or cpu strobes active after reset", $time);
        end
        rf0 = rf_count;
        access(1'b0, sz_word, 32'h0000_0000, '0, lat);
        if (rf_count - rf0 != WORDS) begin
            seq_errors++;
            $display("[ERROR] %0t: first load made %0d refill beats", $time, rf_count - rf0);
        end
        access(1'b0, sz_word, 32'h0000_0004, '0, lat);
        expect_hit(lat, 32'h0000_0004);
        access(1'b1, sz_byte, 32'h0000_0001, {4{8'h5c}}, lat);
        expect_hit(lat, 32'h0000_0001);
        access(1'b1, sz_half, 32'h0000_0006, {2{16'hbeef}}, lat);
        expect_hit(lat, 32'h0000_0006);
        access(1'b1, sz_word, 32'h0000_0008, 32'h1234_5678, lat);
        expect_hit(lat, 32'h0000_0008);
        for (int a = 0; a < 12; a += 4) begin
            access(1'b0, sz_word, 32'(a), '0, lat);
        end
        // three tags on index 4, the third miss evicts the dirty first line
        access(1'b1, sz_word, 32'h0000_0040, 32'hdead_0040, lat);
        access(1'b1, sz_half, 32'h0000_0146, {2{16'h0146}}, lat);
        wb0 = wb_count;
        access(1'b0, sz_word, 32'h0000_0240, '0, lat);
        if (wb_count - wb0 != WORDS) begin
            seq_errors++;
            $display("[ERROR] %0t: eviction made %0d write-back beats", $time, wb_count - wb0);
        end
        access(1'b0, sz_word, 32'h0000_0040, '0, lat);
        for (int n = 0; n < NUM_OPS; n++) begin
            r    = $random(seed);
            addr = $unsigned($random(seed)) & 32'h0000_03ff;
            case ($unsigned(r) % 3)
                0: sz = sz_byte;
                1: sz = sz_half;
                default: sz = sz_word;
            endcase
            if (sz == sz_half) addr[0] = 1'b0;
            if (sz == sz_word) addr[1:0] = 2'b00;
            access(r[4], sz, addr, $random(seed), lat);
            if (r[7:5] == 3'd0) begin
                cpu_req <= 1'b0;   // idle gap
                @(posedge clk);
            end
        end
        cpu_req <= 1'b0;
        repeat (2) @(posedge clk);
        assert_errors = dcache_i.checker_i.fail_count;
        $display("errors: load %0d, bus %0d, sequence %0d, assertion %0d",
                 load_errors, bus_errors, seq_errors, assert_errors);
        if (load_errors + bus_errors + seq_errors + assert_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* list.f */
src/dcache_pkg.sv
src/dcache_tag_ram.sv
src/dcache_data_ram.sv
src/dcache_replacement.sv
src/dcache_controller.sv
src/dcache.sv
test/dcache_mem_model.sv
test/dcache_checker.sv
test/dcache_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= dcache_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx '\*\* PASS \*\*'

clean:
	rm -rf $(OBJ_DIR)
